// File: source/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

//////////////////////////////////////////////////
// widths of the card-to-host channel
//////////////////////////////////////////////////
`define DMA_ADDR_W         48  // host byte address
`define DMA_LEN_W          32  // transfer length in bytes
`define DMA_DATA_W         64  // stream beat width
`define DMA_KEEP_W         8   // one enable per data byte

`define DMA_PAGE_SHIFT     12  // 4 KiB host pages

`define DMA_CMD_DEPTH      4   // split commands in flight to the engine
`define DMA_DATA_DEPTH     16  // write beats buffered ahead of c2h

`define DMA_STATUS_ADDR_W  3   // eight status words
`define DMA_STATUS_DATA_W  32  // status word and counter width

// version word, first status register
`define DMA_FPGA_VERSION   32'h0001_0300

`endif

// File: source/dma_pkg.sv
`include "dma_macros.svh"

package dma_pkg;

  // one write request as seen by the descriptor bypass
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] addr;  // byte address in host memory
    logic [`DMA_LEN_W-1:0]  len;   // bytes, at most one page
  } dma_cmd_t;

  typedef struct packed {
    logic [`DMA_DATA_W-1:0] data;
    logic [`DMA_KEEP_W-1:0] keep;  // byte enables
    logic                   last;  // closes the packet
  } dma_beat_t;

  // status register map
  typedef enum logic [`DMA_STATUS_ADDR_W-1:0] {
    STAT_VERSION        = 3'd0,
    STAT_CMD_COUNT      = 3'd1,  // user commands taken
    STAT_CROSSING_COUNT = 3'd2,  // commands that were split
    STAT_LOAD_COUNT     = 3'd3,  // descriptors handed to engine
    STAT_WORD_COUNT     = 3'd4,  // beats sent on c2h
    STAT_PKT_COUNT      = 3'd5,  // beats with last
    STAT_LENGTH_SUM     = 3'd6,  // low 32 bits of byte total
    STAT_FLUSHED        = 3'd7   // every descriptor has its packet
  } dma_status_idx_e;

endpackage

// File: source/dma_stream_if.sv
`timescale 1ns/1ps

// valid/ready stream, payload held until the transfer cycle
interface dma_stream_if #(
  parameter type payload_t = logic
) ();

  logic     valid;    // source has an item
  logic     ready;    // sink takes it this cycle
  payload_t payload;

  modport source (
    output valid,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  payload,
    output ready
  );

  // counters and checkers only look
  modport monitor (
    input valid,
    input ready,
    input payload
  );

endinterface

// File: source/page_boundary_splitter.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module page_boundary_splitter
  import dma_pkg::*;
(
  input  logic         pcie_clk,
  input  logic         pcie_aresetn,
  dma_stream_if.sink   cmd_in,
  dma_stream_if.source cmd_out,
  output logic         crossing
);

  localparam logic [`DMA_LEN_W-1:0] page_bytes = 1 << `DMA_PAGE_SHIFT;

  dma_cmd_t              in_cmd;      // command at the input
  dma_cmd_t              first_cmd;   // up to the page end
  dma_cmd_t              second_cmd;  // from the next page start
  dma_cmd_t              out_cmd;     // output register
  dma_cmd_t              rest_cmd;    // second half waiting
  logic [`DMA_LEN_W-1:0] page_off;
  logic [`DMA_LEN_W:0]   end_off;     // one extra bit for the carry
  logic                  crosses;
  logic                  in_fire;
  logic                  out_fire;
  logic                  out_valid;
  logic                  pending;     // second half not yet sent
  logic                  armed;       // low through reset
  logic                  can_load;    // output register free this cycle

  //////////////////////////////////////////////////
  // split arithmetic
  //////////////////////////////////////////////////
  always_comb begin
    in_cmd          = cmd_in.payload;
    page_off        = {{(`DMA_LEN_W-`DMA_PAGE_SHIFT){1'b0}},
                       in_cmd.addr[`DMA_PAGE_SHIFT-1:0]};
    end_off         = {1'b0, page_off} + {1'b0, in_cmd.len};
    crosses         = end_off > {1'b0, page_bytes};  // exactly to page end is fine
    first_cmd.addr  = in_cmd.addr;
    first_cmd.len   = page_bytes - page_off;
    second_cmd.addr = {in_cmd.addr[`DMA_ADDR_W-1:`DMA_PAGE_SHIFT] + 1'b1,
                       {`DMA_PAGE_SHIFT{1'b0}}};
    second_cmd.len  = in_cmd.len - first_cmd.len;   // remainder
  end

  assign can_load     = !out_valid || cmd_out.ready;
  assign cmd_in.ready = armed && !pending && can_load;  // hold off during second half
  assign in_fire      = cmd_in.valid && cmd_in.ready;
  assign out_fire     = out_valid && cmd_out.ready;
  assign crossing     = in_fire && crosses;            // one pulse per split

  assign cmd_out.valid   = out_valid;
  assign cmd_out.payload = out_cmd;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      armed     <= 1'b0;
      out_valid <= 1'b0;
      pending   <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (in_fire) begin
        out_valid <= 1'b1;
        pending   <= crosses;
      end else if (pending && can_load) begin
        out_valid <= 1'b1;  // second half goes out back to back
        pending   <= 1'b0;
      end else if (out_fire) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (in_fire) begin
      out_cmd  <= crosses ? first_cmd : in_cmd;
      rest_cmd <= second_cmd;
    end else if (pending && can_load) begin
      out_cmd <= rest_cmd;
    end
  end

  // the user side must never send an empty or multi-page request
  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    in_fire |-> in_cmd.len != '0)
    else $error("splitter: zero length command");

  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    in_fire |-> in_cmd.len <= page_bytes)
    else $error("splitter: command longer than one page");

endmodule

// File: source/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic         pcie_clk,
  input  logic         pcie_aresetn,
  dma_stream_if.sink   wr,
  dma_stream_if.source rd
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);
  localparam logic [cnt_w-1:0] full_count = cnt_w'(DEPTH);

  payload_t         mem [DEPTH];  // payload storage
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;        // items held
  logic             wr_fire;
  logic             rd_fire;

  // wrap without needing a power of two depth
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    next_ptr = (ptr == ptr_w'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr.ready   = count != full_count;  // drops when full
  assign rd.valid   = count != '0;
  assign rd.payload = mem[rd_ptr];          // head of queue
  assign wr_fire    = wr.valid && wr.ready;
  assign rd_fire    = rd.valid && rd.ready;

  always_ff @(posedge pcie_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr.payload;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // a full queue never moves its write pointer
  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (count == full_count) |=> $stable(wr_ptr))
    else $error("fifo: write accepted while full");

  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    count <= full_count)
    else $error("fifo: count above depth");

  // head stays put while the consumer stalls
  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (rd.valid && !rd.ready) |=> (rd.valid && $stable(rd.payload)))
    else $error("fifo: output changed before transfer");

endmodule

// File: source/descriptor_loader.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module descriptor_loader
  import dma_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_aresetn,
  dma_stream_if.sink             cmd,
  input  logic                   dsc_byp_ready,
  output logic                   dsc_byp_load,
  output logic [`DMA_ADDR_W-1:0] dsc_byp_addr,
  output logic [`DMA_LEN_W-1:0]  dsc_byp_len
);

  dma_cmd_t cmd_word;
  logic     cmd_fire;

  assign cmd.ready = dsc_byp_ready;  // engine back-pressure stalls the queue
  assign cmd_fire  = cmd.valid && cmd.ready;
  assign cmd_word  = cmd.payload;

  //////////////////////////////////////////////////
  // bypass load, one cycle after acceptance
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      dsc_byp_load <= 1'b0;
    end else begin
      dsc_byp_load <= cmd_fire;  // single pulse per descriptor
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (cmd_fire) begin
      dsc_byp_addr <= cmd_word.addr;
      dsc_byp_len  <= cmd_word.len;
    end
  end

  // back-to-back loads only from back-to-back acceptances
  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (dsc_byp_load && $past(dsc_byp_load)) |-> ($past(cmd_fire) && $past(cmd_fire, 2)))
    else $error("loader: load held high without a new descriptor");

endmodule

// File: source/dma_stats.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_stats
  import dma_pkg::*;
(
  input  logic                          pcie_clk,
  input  logic                          pcie_aresetn,
  dma_stream_if.monitor                 user_cmd,
  input  logic                          crossing,
  input  logic                          dsc_byp_load,
  input  logic                          beat_valid,
  input  logic                          beat_ready,
  input  logic                          beat_last,
  input  logic [`DMA_STATUS_ADDR_W-1:0] status_addr,
  output logic [`DMA_STATUS_DATA_W-1:0] status_data
);

  localparam int cnt_w = `DMA_STATUS_DATA_W;

  dma_cmd_t         seen_cmd;
  logic             user_fire;
  logic             beat_fire;
  logic [cnt_w-1:0] cmd_count;
  logic [cnt_w-1:0] len_sum;      // wraps, low bits only
  logic [cnt_w-1:0] cross_count;
  logic [cnt_w-1:0] load_count;
  logic [cnt_w-1:0] word_count;
  logic [cnt_w-1:0] pkt_count;
  logic [cnt_w-1:0] status_word;

  assign seen_cmd  = user_cmd.payload;
  assign user_fire = user_cmd.valid && user_cmd.ready;
  assign beat_fire = beat_valid && beat_ready;  // beat leaves data queue

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      cmd_count   <= '0;
      len_sum     <= '0;
      cross_count <= '0;
      load_count  <= '0;
      word_count  <= '0;
      pkt_count   <= '0;
    end else begin
      if (user_fire) begin
        cmd_count <= cmd_count + 1'b1;
        len_sum   <= len_sum + cnt_w'(seen_cmd.len);  // before any split
      end
      if (crossing) begin
        cross_count <= cross_count + 1'b1;
      end
      if (dsc_byp_load) begin
        load_count <= load_count + 1'b1;
      end
      if (beat_fire) begin
        word_count <= word_count + 1'b1;
        if (beat_last) begin
          pkt_count <= pkt_count + 1'b1;
        end
      end
    end
  end

  always_comb begin
    status_word = '0;
    case (dma_status_idx_e'(status_addr))
      STAT_VERSION:        status_word = `DMA_FPGA_VERSION;
      STAT_CMD_COUNT:      status_word = cmd_count;
      STAT_CROSSING_COUNT: status_word = cross_count;
      STAT_LOAD_COUNT:     status_word = load_count;
      STAT_WORD_COUNT:     status_word = word_count;
      STAT_PKT_COUNT:      status_word = pkt_count;
      STAT_LENGTH_SUM:     status_word = len_sum;
      STAT_FLUSHED:        status_word = cnt_w'(load_count == pkt_count);
      default:             status_word = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      status_data <= '0;
    end else begin
      status_data <= status_word;  // read data one cycle after address
    end
  end

  // every descriptor traces back to a user command or its split half
  assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    load_count <= cmd_count + cross_count)
    else $error("stats: more loads than commands and splits");

endmodule

// File: source/dma_inf_top.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dma_inf_top
  import dma_pkg::*;
(
  input  logic                          pcie_clk,
  input  logic                          pcie_aresetn,
  // user write commands
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  input  logic [`DMA_ADDR_W-1:0]        cmd_addr,
  input  logic [`DMA_LEN_W-1:0]         cmd_len,
  // user write data
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  logic [`DMA_DATA_W-1:0]        wr_data,
  input  logic [`DMA_KEEP_W-1:0]        wr_keep,
  input  logic                          wr_last,
  // engine c2h stream
  output logic                          c2h_valid,
  input  logic                          c2h_ready,
  output logic [`DMA_DATA_W-1:0]        c2h_data,
  output logic [`DMA_KEEP_W-1:0]        c2h_keep,
  output logic                          c2h_last,
  // engine descriptor bypass
  input  logic                          dsc_byp_ready,
  output logic                          dsc_byp_load,
  output logic [`DMA_ADDR_W-1:0]        dsc_byp_addr,
  output logic [`DMA_LEN_W-1:0]         dsc_byp_len,
  // status port
  input  logic [`DMA_STATUS_ADDR_W-1:0] status_addr,
  output logic [`DMA_STATUS_DATA_W-1:0] status_data
);

  dma_stream_if #(.payload_t(dma_cmd_t))  user_cmd ();
  dma_stream_if #(.payload_t(dma_cmd_t))  split_cmd ();
  dma_stream_if #(.payload_t(dma_cmd_t))  queued_cmd ();
  dma_stream_if #(.payload_t(dma_beat_t)) wr_beat ();
  dma_stream_if #(.payload_t(dma_beat_t)) c2h_beat ();

  logic crossing;  // split pulse to stats

  //////////////////////////////////////////////////
  // ports into streams
  //////////////////////////////////////////////////
  assign user_cmd.valid   = cmd_valid;
  assign user_cmd.payload = '{addr: cmd_addr, len: cmd_len};
  assign cmd_ready        = user_cmd.ready;

  assign wr_beat.valid   = wr_valid;
  assign wr_beat.payload = '{data: wr_data, keep: wr_keep, last: wr_last};
  assign wr_ready        = wr_beat.ready;

  assign c2h_valid      = c2h_beat.valid;
  assign c2h_beat.ready = c2h_ready;
  assign c2h_data       = c2h_beat.payload.data;
  assign c2h_keep       = c2h_beat.payload.keep;
  assign c2h_last       = c2h_beat.payload.last;

  //////////////////////////////////////////////////
  // command path
  //////////////////////////////////////////////////
  page_boundary_splitter splitter_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_in       (user_cmd),
    .cmd_out      (split_cmd),
    .crossing     (crossing)
  );

  stream_fifo #(.payload_t(dma_cmd_t), .DEPTH(`DMA_CMD_DEPTH)) cmd_fifo_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr           (split_cmd),
    .rd           (queued_cmd)
  );

  descriptor_loader loader_i (
    .pcie_clk      (pcie_clk),
    .pcie_aresetn  (pcie_aresetn),
    .cmd           (queued_cmd),
    .dsc_byp_ready (dsc_byp_ready),
    .dsc_byp_load  (dsc_byp_load),
    .dsc_byp_addr  (dsc_byp_addr),
    .dsc_byp_len   (dsc_byp_len)
  );

  // data path, beats straight through to c2h
  stream_fifo #(.payload_t(dma_beat_t), .DEPTH(`DMA_DATA_DEPTH)) data_fifo_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr           (wr_beat),
    .rd           (c2h_beat)
  );

  dma_stats stats_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .user_cmd     (user_cmd),
    .crossing     (crossing),
    .dsc_byp_load (dsc_byp_load),
    .beat_valid   (c2h_valid),   // counted as it leaves the queue
    .beat_ready   (c2h_ready),
    .beat_last    (c2h_last),
    .status_addr  (status_addr),
    .status_data  (status_data)
  );

endmodule

// File: bench/tb_dma_inf.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module tb_dma_inf;

  localparam logic [31:0] page_bytes = 32'd1 << `DMA_PAGE_SHIFT;

  logic                          pcie_clk = 1'b0;
  logic                          pcie_aresetn;
  logic                          cmd_valid;
  logic                          cmd_ready;
  logic [`DMA_ADDR_W-1:0]        cmd_addr;
  logic [`DMA_LEN_W-1:0]         cmd_len;
  logic                          wr_valid;
  logic                          wr_ready;
  logic [`DMA_DATA_W-1:0]        wr_data;
  logic [`DMA_KEEP_W-1:0]        wr_keep;
  logic                          wr_last;
  logic                          c2h_valid;
  logic                          c2h_ready;
  logic [`DMA_DATA_W-1:0]        c2h_data;
  logic [`DMA_KEEP_W-1:0]        c2h_keep;
  logic                          c2h_last;
  logic                          dsc_byp_ready;
  logic                          dsc_byp_load;
  logic [`DMA_ADDR_W-1:0]        dsc_byp_addr;
  logic [`DMA_LEN_W-1:0]         dsc_byp_len;
  logic [`DMA_STATUS_ADDR_W-1:0] status_addr;
  logic [`DMA_STATUS_DATA_W-1:0] status_data;

  logic [`DMA_ADDR_W-1:0] cmd_addr_q [$];   // user commands to drive
  logic [`DMA_LEN_W-1:0]  cmd_len_q [$];
  logic [`DMA_DATA_W-1:0] beat_data_q [$];  // write beats to drive
  logic [`DMA_KEEP_W-1:0] beat_keep_q [$];
  logic                   beat_last_q [$];
  logic [`DMA_ADDR_W-1:0] exp_addr_q [$];   // descriptors after the split rule
  logic [`DMA_LEN_W-1:0]  exp_len_q [$];
  logic [`DMA_DATA_W-1:0] exp_data_q [$];   // c2h beats still owed
  logic [`DMA_KEEP_W-1:0] exp_keep_q [$];
  logic                   exp_last_q [$];
  logic [2:0]             stat_idx_q [$];   // status reads from the file
  logic [31:0]            stat_val_q [$];

  integer      seed = 28;
  bit          engine_on = 1'b0;
  int          error_count = 0;
  int          check_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          line_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          loads_seen = 0;
  int          words_seen = 0;
  int          desc_errors = 0;
  int          beat_errors = 0;
  int          mon_before = 0;
  int          tot_cmds = 0;
  int          tot_cross = 0;
  int          tot_loads = 0;
  int          tot_words = 0;
  int          tot_pkts = 0;
  logic [31:0] tot_len_sum = '0;  // wraps like the counter

  dma_inf_top dut_i (.*);

  always #20 pcie_clk = ~pcie_clk;  // 40 ns period

  //////////////////////////////////////////////////
  // checking and reporting
  //////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] got);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, got);
    end
  endtask

  task automatic report_test(input string name, input int errors);
    tests_run++;
    if (errors == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors);
    end
  endtask

  // expected status word from the running totals
  function automatic logic [31:0] status_expect(input int idx, input bit after_traffic);
    logic [31:0] word;
    word = '0;
    case (idx)
      0: word = `DMA_FPGA_VERSION;
      1: word = after_traffic ? 32'(tot_cmds) : '0;
      2: word = after_traffic ? 32'(tot_cross) : '0;
      3: word = after_traffic ? 32'(tot_loads) : '0;
      4: word = after_traffic ? 32'(tot_words) : '0;
      5: word = after_traffic ? 32'(tot_pkts) : '0;
      6: word = after_traffic ? tot_len_sum : '0;
      default: word = after_traffic ? {31'd0, tot_loads == tot_pkts} : 32'd1;  // 0 == 0
    endcase
    return word;
  endfunction

  //////////////////////////////////////////////////
  // stimulus file and expected values
  //////////////////////////////////////////////////
  task automatic push_command(input logic [47:0] addr, input logic [31:0] len);
    logic [32:0] end_off;
    logic [31:0] head_len;
    end_off = {1'b0, 32'(addr[`DMA_PAGE_SHIFT-1:0])} + {1'b0, len};
    tot_cmds++;
    tot_len_sum += len;
    cmd_addr_q.push_back(addr);
    cmd_len_q.push_back(len);
    if (end_off > {1'b0, page_bytes}) begin  // runs past the page end
      head_len = page_bytes - 32'(addr[`DMA_PAGE_SHIFT-1:0]);
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(head_len);
      exp_addr_q.push_back(((addr >> `DMA_PAGE_SHIFT) + 48'd1) << `DMA_PAGE_SHIFT);
      exp_len_q.push_back(len - head_len);  // rest from next page start
      tot_cross++;
      tot_loads += 2;
    end else begin
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(len);
      tot_loads++;
    end
  endtask

  task automatic make_packet(input int beats);
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [31:0] r_keep;
    logic [7:0]  keep;
    for (int b = 0; b < beats; b++) begin
      r_hi = $random(seed);
      r_lo = $random(seed);
      r_keep = $random(seed);
      keep = (r_keep[7:0] == 8'h00) ? 8'h01 : r_keep[7:0];  // partial tail
      keep = (b == beats - 1) ? keep : 8'hff;
      beat_data_q.push_back({r_hi, r_lo});
      beat_keep_q.push_back(keep);
      beat_last_q.push_back(b == beats - 1);
      exp_data_q.push_back({r_hi, r_lo});
      exp_keep_q.push_back(keep);
      exp_last_q.push_back(b == beats - 1);
      tot_words++;
    end
    tot_pkts++;
  endtask

  task automatic load_stimulus();
    int          fd;
    int          code;
    string       kind;
    string       rest;
    logic [47:0] a;
    logic [31:0] b;
    fd = $fopen("bench/dma_stimulus.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("stimulus file bench/dma_stimulus.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %s", kind);
      if (code != 1) break;
      line_count++;
      if (kind == "#") begin
        code = $fgets(rest, fd);  // skip comment text
      end else if (kind == "C") begin
        code = $fscanf(fd, " %h %h", a, b);
        push_command(a, b);
      end else if (kind == "P") begin
        code = $fscanf(fd, " %h", b);
        make_packet(int'(b));
      end else if (kind == "S") begin
        code = $fscanf(fd, " %h %h", a, b);
        stat_idx_q.push_back(a[2:0]);
        stat_val_q.push_back(b);
      end else begin
        error_count++;
        $display("stimulus line %0d has unknown kind %s", line_count, kind);
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // drivers, engine model and monitors
  //////////////////////////////////////////////////
  task automatic drive_commands();
    @(posedge pcie_clk);
    #2;
    for (int k = 0; k < cmd_addr_q.size(); k++) begin
      cmd_valid = 1'b1;
      cmd_addr = cmd_addr_q[k];
      cmd_len = cmd_len_q[k];
      @(posedge pcie_clk);
      while (!cmd_ready) @(posedge pcie_clk);  // held until taken
      #2;
    end
    cmd_valid = 1'b0;
  endtask

  task automatic drive_data();
    @(posedge pcie_clk);
    #2;
    for (int k = 0; k < beat_data_q.size(); k++) begin
      wr_valid = 1'b1;
      wr_data = beat_data_q[k];
      wr_keep = beat_keep_q[k];
      wr_last = beat_last_q[k];
      @(posedge pcie_clk);
      while (!wr_ready) @(posedge pcie_clk);  // queue full
      #2;
    end
    wr_valid = 1'b0;
  endtask

  task automatic read_status(input logic [2:0] idx, output logic [31:0] value);
    @(posedge pcie_clk);
    #2;
    status_addr = idx;
    @(posedge pcie_clk);  // word registered here
    @(posedge pcie_clk);
    value = status_data;
  endtask

  // engine model with ready about three cycles in four
  always begin
    @(posedge pcie_clk);
    #2;
    if (engine_on) begin
      dsc_byp_ready = ($random(seed) & 3) != 0;
      c2h_ready = ($random(seed) & 3) != 0;
    end
  end

  always @(posedge pcie_clk) begin
    if (pcie_aresetn && dsc_byp_load) begin
      loads_seen++;
      mon_before = error_count;
      if (exp_addr_q.size() == 0) begin
        error_count++;
        $display("error at %0t: descriptor load with no command left to expect", $time);
      end else begin
        check_value("dsc_byp_addr", 64'(exp_addr_q.pop_front()), 64'(dsc_byp_addr));
        check_value("dsc_byp_len", 64'(exp_len_q.pop_front()), 64'(dsc_byp_len));
      end
      desc_errors += error_count - mon_before;
    end
    if (pcie_aresetn && c2h_valid && c2h_ready) begin
      words_seen++;
      mon_before = error_count;
      if (exp_data_q.size() == 0) begin
        error_count++;
        $display("error at %0t: c2h beat sent with no write beat left to expect", $time);
      end else begin
        check_value("c2h_data", exp_data_q.pop_front(), c2h_data);
        check_value("c2h_keep", 64'(exp_keep_q.pop_front()), 64'(c2h_keep));
        check_value("c2h_last", 64'(exp_last_q.pop_front()), 64'(c2h_last));
      end
      beat_errors += error_count - mon_before;
    end
  end

  // limit scales with the stimulus file
  initial begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge pcie_clk);
      cycle_count++;
    end
    $display("timeout: design stopped making progress");
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int          start;
    logic [31:0] value;
    $timeformat(-9, 0, " ns", 0);
    pcie_aresetn = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_len = '0;
    wr_valid = 1'b0;
    wr_data = '0;
    wr_keep = '0;
    wr_last = 1'b0;
    c2h_ready = 1'b0;
    dsc_byp_ready = 1'b0;
    status_addr = '0;
    load_stimulus();
    cycle_limit = 50 * line_count;
    repeat (2) @(posedge pcie_clk);
    #2;
    pcie_aresetn = 1'b1;

    start = error_count;  // idle outputs and cleared counters
    for (int i = 0; i < 8; i++) begin
      read_status(3'(i), value);
      check_value($sformatf("status_data[%0d]", i), 64'(status_expect(i, 1'b0)), 64'(value));
      check_value("dsc_byp_load", 64'(0), 64'(dsc_byp_load));
      check_value("c2h_valid", 64'(0), 64'(c2h_valid));
    end
    report_test("reset state", error_count - start);

    engine_on = 1'b1;
    fork
      drive_commands();
      drive_data();
    join
    while (loads_seen < tot_loads || words_seen < tot_words) @(posedge pcie_clk);
    repeat (8) @(posedge pcie_clk);  // catch extra loads or beats
    start = error_count;
    check_value("dsc_byp_load count", 64'(tot_loads), 64'(loads_seen));
    desc_errors += error_count - start;
    start = error_count;
    check_value("c2h beat count", 64'(tot_words), 64'(words_seen));
    beat_errors += error_count - start;
    report_test("descriptor split and order", desc_errors);
    report_test("c2h data order", beat_errors);

    start = error_count;
    for (int i = 0; i < stat_idx_q.size(); i++) begin
      read_status(stat_idx_q[i], value);
      check_value($sformatf("status_data[%0d]", stat_idx_q[i]),
                  64'(status_expect(int'(stat_idx_q[i]), 1'b1)), 64'(value));
      check_value($sformatf("status_data[%0d] file value", stat_idx_q[i]),
                  64'(stat_val_q[i]), 64'(value));
    end
    report_test("status registers", error_count - start);

    $display("checks %0d, errors %0d, tests failed %0d of %0d",
             check_count, error_count, tests_failed, tests_run);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: bench/dma_stimulus.txt
# C addr len : user write command, hex
# P beats : one write packet, hex beat count
# S index value : status word expected after traffic, hex
C 000010000000 100
C 000010000100 f00
C 000020000f00 200
C 123456789ff8 10
C 00003000000c 1000
C 000040000800 800
C 000050000000 1
P 1
P 4
P 2
P 8
P 3
P 1
P 5
P 2
P 6
P 2
S 0 00010300
S 1 7
S 2 3
S 3 a
S 4 22
S 5 a
S 6 2a11
S 7 1

// File: dma_inf_top.f
+incdir+source
source/dma_pkg.sv
source/dma_stream_if.sv
source/page_boundary_splitter.sv
source/stream_fifo.sv
source/descriptor_loader.sv
source/dma_stats.sv
source/dma_inf_top.sv
bench/tb_dma_inf.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_dma_inf \
  -f dma_inf_top.f

out=$(./obj_dir/Vtb_dma_inf)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
